/* aap_core_pkg.sv */
package aap_core_pkg;

   // **************************************************
   // Datapath widths
   // **************************************************

   // General register and ALU word
   localparam int WORD_WIDTH = 16;

   // Program counter, addresses 24-bit instruction space
   localparam int PC_WIDTH = 24;

   // Register numbers in a 16-bit instruction
   localparam int REG_NUM_WIDTH = 3;

   // Size of the register file
   localparam int NUM_REGS = 8;

   typedef logic [WORD_WIDTH-1:0]    word_t;
   typedef logic [PC_WIDTH-1:0]      pc_t;
   typedef logic [REG_NUM_WIDTH-1:0] reg_num_t;

endpackage

/* aap_decode.sv */
`timescale 1ns/1ps

module aap_decode (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  instr_valid,
   input  aap_isa_pkg::instr_t   instr,
   output logic                  dec_valid,
   output aap_isa_pkg::class_t   dec_class,
   output aap_isa_pkg::opcode_t  dec_opcode,
   output aap_core_pkg::reg_num_t dec_rd,
   output aap_core_pkg::reg_num_t dec_ra,
   output aap_core_pkg::reg_num_t dec_rb,
   output aap_core_pkg::word_t   dec_imm3,
   output aap_core_pkg::word_t   dec_imm6,
   output aap_core_pkg::pc_t     dec_simm3d,
   output aap_core_pkg::pc_t     dec_simm6,
   output aap_core_pkg::pc_t     dec_simm9
);

   import aap_core_pkg::*;
   import aap_isa_pkg::*;

   // Captured instruction word
   instr_t instr_q;

   // **************************************************
   // Capture stage
   // **************************************************

   // Strobe follows the input one cycle later
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         dec_valid <= 1'b0;
      end else begin
         dec_valid <= instr_valid;
      end
   end

   // Word only loads on a strobe, held otherwise
   always_ff @(posedge clk) begin
      if (instr_valid) begin
         instr_q <= instr;
      end
   end

   // **************************************************
   // Field extraction
   // **************************************************

   assign dec_class  = instr_q[CLASS_MSB:CLASS_LSB];
   assign dec_opcode = instr_q[OPCODE_MSB:OPCODE_LSB];

   // Register numbers
   assign dec_rd = instr_q[RD_MSB:RD_LSB];
   assign dec_ra = instr_q[RA_MSB:RA_LSB];
   assign dec_rb = instr_q[RB_MSB:RB_LSB];

   // Unsigned ALU immediates, zero extended to a word
   assign dec_imm3 = word_t'(instr_q[IMM3_MSB:IMM3_LSB]);
   assign dec_imm6 = word_t'(instr_q[IMM6_MSB:IMM6_LSB]);

   // Branch offsets, sign extended to PC width
   // simm3d shares bits with rd, simm6 spans rd and ra
   assign dec_simm3d = pc_t'($signed(instr_q[SIMM3D_MSB:SIMM3D_LSB]));
   assign dec_simm6  = pc_t'($signed(instr_q[SIMM6_MSB:SIMM6_LSB]));
   assign dec_simm9  = pc_t'($signed(instr_q[SIMM9_MSB:SIMM9_LSB]));

endmodule

/* aap_exec_core.sv */
`timescale 1ns/1ps

module aap_exec_core (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   instr_valid,
   input  aap_isa_pkg::instr_t    instr,
   output logic                   done,
   output logic                   wb_en,
   output aap_core_pkg::reg_num_t wb_num,
   output aap_core_pkg::word_t    wb_data,
   output aap_core_pkg::pc_t      pc,
   output logic                   carry
);

   import aap_core_pkg::*;
   import aap_isa_pkg::*;

   // **************************************************
   // Decode to execute and register file
   // **************************************************

   logic     dec_valid;
   class_t   dec_class;
   opcode_t  dec_opcode;
   reg_num_t dec_rd;
   reg_num_t dec_ra;
   reg_num_t dec_rb;
   word_t    dec_imm3;
   word_t    dec_imm6;
   pc_t      dec_simm3d;
   pc_t      dec_simm6;
   pc_t      dec_simm9;

   // Register reads
   word_t    rd_data_a;
   word_t    rd_data_b;
   word_t    rd_data_d;

   // Write back from execute, lands at end of execute cycle
   logic     wr_en;
   reg_num_t wr_num;
   word_t    wr_data;

   aap_decode u_decode (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .dec_valid   (dec_valid),
      .dec_class   (dec_class),
      .dec_opcode  (dec_opcode),
      .dec_rd      (dec_rd),
      .dec_ra      (dec_ra),
      .dec_rb      (dec_rb),
      .dec_imm3    (dec_imm3),
      .dec_imm6    (dec_imm6),
      .dec_simm3d  (dec_simm3d),
      .dec_simm6   (dec_simm6),
      .dec_simm9   (dec_simm9)
   );

   aap_regfile u_regfile (
      .clk       (clk),
      .rst       (rst),
      .rd_num_a  (dec_ra),
      .rd_num_b  (dec_rb),
      .rd_num_d  (dec_rd),
      .wr_en     (wr_en),
      .wr_num    (wr_num),
      .wr_data   (wr_data),
      .rd_data_a (rd_data_a),
      .rd_data_b (rd_data_b),
      .rd_data_d (rd_data_d)
   );

   aap_execute u_execute (
      .clk        (clk),
      .rst        (rst),
      .dec_valid  (dec_valid),
      .dec_class  (dec_class),
      .dec_opcode (dec_opcode),
      .dec_rd     (dec_rd),
      .dec_ra     (dec_ra),
      .dec_rb     (dec_rb),
      .dec_imm3   (dec_imm3),
      .dec_imm6   (dec_imm6),
      .dec_simm3d (dec_simm3d),
      .dec_simm6  (dec_simm6),
      .dec_simm9  (dec_simm9),
      .rd_data_a  (rd_data_a),
      .rd_data_b  (rd_data_b),
      .rd_data_d  (rd_data_d),
      .wr_en      (wr_en),
      .wr_num     (wr_num),
      .wr_data    (wr_data),
      .done       (done),
      .wb_en      (wb_en),
      .wb_num     (wb_num),
      .wb_data    (wb_data),
      .pc         (pc),
      .carry      (carry)
   );

endmodule

/* aap_execute.sv */
`timescale 1ns/1ps

module aap_execute (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   dec_valid,
   input  aap_isa_pkg::class_t    dec_class,
   input  aap_isa_pkg::opcode_t   dec_opcode,
   input  aap_core_pkg::reg_num_t dec_rd,
   input  aap_core_pkg::reg_num_t dec_ra,
   input  aap_core_pkg::reg_num_t dec_rb,
   input  aap_core_pkg::word_t    dec_imm3,
   input  aap_core_pkg::word_t    dec_imm6,
   input  aap_core_pkg::pc_t      dec_simm3d,
   input  aap_core_pkg::pc_t      dec_simm6,
   input  aap_core_pkg::pc_t      dec_simm9,
   input  aap_core_pkg::word_t    rd_data_a,
   input  aap_core_pkg::word_t    rd_data_b,
   input  aap_core_pkg::word_t    rd_data_d,
   output logic                   wr_en,
   output aap_core_pkg::reg_num_t wr_num,
   output aap_core_pkg::word_t    wr_data,
   output logic                   done,
   output logic                   wb_en,
   output aap_core_pkg::reg_num_t wb_num,
   output aap_core_pkg::word_t    wb_data,
   output aap_core_pkg::pc_t      pc,
   output logic                   carry
);

   import aap_core_pkg::*;
   import aap_isa_pkg::*;

   // Operand B after immediate select
   word_t             alu_b;
   logic [3:0]        shamt;
   logic [16:0]       sum_full;
   logic [16:0]       diff_full;
   logic signed [16:0] asr_full;

   word_t alu_res;
   logic  alu_carry;

   // Flow control
   logic  taken;
   pc_t   rel_off;
   pc_t   pc_inc;
   pc_t   next_pc;
   logic  next_carry;
   logic  is_link;

   // **************************************************
   // ALU datapath
   // **************************************************

   // ADDI to LSRI take imm3 in place of rb
   assign alu_b = (dec_opcode >= ALU_ADDI && dec_opcode <= ALU_LSRI) ? dec_imm3 : rd_data_b;
   assign shamt = alu_b[3:0];

   // Carry is the 17th bit of the unsigned result
   assign sum_full  = {1'b0, rd_data_a} + {1'b0, alu_b};
   assign diff_full = {1'b0, rd_data_a} - {1'b0, alu_b};

   // Carry sits above ra as the sign of a 17-bit value
   assign asr_full = $signed({carry, rd_data_a}) >>> shamt;

   always_comb begin
      alu_res   = rd_data_d;
      alu_carry = carry;
      case (dec_opcode)
         // Rewrites rd with its own value
         ALU_NOP: alu_res = rd_data_d;
         ALU_ADD, ALU_ADDI: begin
            alu_res   = sum_full[15:0];
            alu_carry = sum_full[16];
         end
         ALU_SUB, ALU_SUBI: begin
            alu_res   = diff_full[15:0];
            alu_carry = diff_full[16];
         end
         ALU_AND: alu_res = rd_data_a & rd_data_b;
         ALU_OR:  alu_res = rd_data_a | rd_data_b;
         ALU_XOR: alu_res = rd_data_a ^ rd_data_b;
         ALU_ASR, ALU_ASRI: alu_res = asr_full[15:0];
         ALU_LSL, ALU_LSLI: alu_res = rd_data_a << shamt;
         ALU_LSR, ALU_LSRI: alu_res = rd_data_a >> shamt;
         ALU_MOV:  alu_res = rd_data_a;
         ALU_MOVI: alu_res = dec_imm6;
         default:  alu_res = rd_data_d;
      endcase
   end

   // **************************************************
   // Flow of control
   // **************************************************

   assign pc_inc  = pc + pc_t'(1);
   assign is_link = (dec_opcode == FLOW_BAL) || (dec_opcode == FLOW_JAL);

   // Branch condition, relative and absolute forms share tests
   always_comb begin
      case (dec_opcode)
         FLOW_BRA, FLOW_BAL, FLOW_JMP, FLOW_JAL: taken = 1'b1;
         FLOW_BEQ, FLOW_JEQ: taken = (rd_data_a == rd_data_b);
         FLOW_BNE, FLOW_JNE: taken = (rd_data_a != rd_data_b);
         FLOW_BLTS, FLOW_JLTS: taken = ($signed(rd_data_a) < $signed(rd_data_b));
         FLOW_BLES, FLOW_JLES: taken = ($signed(rd_data_a) <= $signed(rd_data_b));
         FLOW_BLTU, FLOW_JLTU: taken = (rd_data_a < rd_data_b);
         FLOW_BLEU, FLOW_JLEU: taken = (rd_data_a <= rd_data_b);
         default: taken = 1'b0;
      endcase
   end

   // Offset width depends on branch form
   always_comb begin
      case (dec_opcode)
         FLOW_BRA: rel_off = dec_simm9;
         FLOW_BAL: rel_off = dec_simm6;
         default:  rel_off = dec_simm3d;
      endcase
   end

   // **************************************************
   // Next state and register write
   // **************************************************

   always_comb begin
      next_pc    = pc_inc;
      next_carry = carry;
      wr_en      = 1'b0;
      wr_num     = dec_rd;
      wr_data    = alu_res;
      case (dec_class)
         CLASS_ALU: begin
            // Every ALU word writes rd
            wr_en      = dec_valid;
            next_carry = alu_carry;
         end
         CLASS_FLOW: begin
            // Link is only the low half of the return address
            wr_en   = dec_valid & is_link;
            wr_num  = dec_rb;
            wr_data = pc_inc[15:0];
            if (taken && dec_opcode[FLOW_ABS_BIT]) begin
               next_pc = {pc[PC_WIDTH-1:16], rd_data_d};
            end else if (taken) begin
               next_pc = pc + rel_off;
            end
         end
         CLASS_LDST, CLASS_MISC: begin
            // Step over, nothing else changes
            next_pc = pc_inc;
         end
         default: next_pc = pc_inc;
      endcase
   end

   // Control and architectural state
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         done  <= 1'b0;
         wb_en <= 1'b0;
         pc    <= '0;
         carry <= 1'b0;
      end else begin
         done  <= dec_valid;
         wb_en <= wr_en;
         if (dec_valid) begin
            pc    <= next_pc;
            carry <= next_carry;
         end
      end
   end

   // Report of the write, valid alongside done
   always_ff @(posedge clk) begin
      if (dec_valid) begin
         wb_num  <= wr_num;
         wb_data <= wr_data;
      end
   end

endmodule

/* aap_isa_pkg.sv */
package aap_isa_pkg;

   // **************************************************
   // Word and field widths
   // **************************************************

   localparam int INSTR_WIDTH  = 16;
   localparam int CLASS_WIDTH  = 2;
   localparam int OPCODE_WIDTH = 4;

   typedef logic [INSTR_WIDTH-1:0]  instr_t;
   typedef logic [CLASS_WIDTH-1:0]  class_t;
   typedef logic [OPCODE_WIDTH-1:0] opcode_t;

   // Field positions in a 16-bit word, bit 15 is ignored
   localparam int CLASS_MSB  = 14;
   localparam int CLASS_LSB  = 13;
   localparam int OPCODE_MSB = 12;
   localparam int OPCODE_LSB = 9;
   localparam int RD_MSB     = 8;
   localparam int RD_LSB     = 6;
   localparam int RA_MSB     = 5;
   localparam int RA_LSB     = 3;
   localparam int RB_MSB     = 2;
   localparam int RB_LSB     = 0;

   // Immediates overlay the register fields
   localparam int IMM3_MSB   = RB_MSB;
   localparam int IMM3_LSB   = RB_LSB;
   localparam int IMM6_MSB   = 5;
   localparam int IMM6_LSB   = 0;
   localparam int SIMM3D_MSB = RD_MSB;
   localparam int SIMM3D_LSB = RD_LSB;
   localparam int SIMM6_MSB  = 8;
   localparam int SIMM6_LSB  = 3;
   localparam int SIMM9_MSB  = 8;
   localparam int SIMM9_LSB  = 0;

   // **************************************************
   // Instruction classes
   // **************************************************

   localparam class_t CLASS_ALU  = 2'b00;
   localparam class_t CLASS_LDST = 2'b01;
   localparam class_t CLASS_FLOW = 2'b10;
   localparam class_t CLASS_MISC = 2'b11;

   // ALU opcodes, immediate forms mirror ADD to LSR
   localparam opcode_t ALU_NOP  = 4'b0000;
   localparam opcode_t ALU_ADD  = 4'b0001;
   localparam opcode_t ALU_SUB  = 4'b0010;
   localparam opcode_t ALU_AND  = 4'b0011;
   localparam opcode_t ALU_OR   = 4'b0100;
   localparam opcode_t ALU_XOR  = 4'b0101;
   localparam opcode_t ALU_ASR  = 4'b0110;
   localparam opcode_t ALU_LSL  = 4'b0111;
   localparam opcode_t ALU_LSR  = 4'b1000;
   localparam opcode_t ALU_MOV  = 4'b1001;
   localparam opcode_t ALU_ADDI = 4'b1010;
   localparam opcode_t ALU_SUBI = 4'b1011;
   localparam opcode_t ALU_ASRI = 4'b1100;
   localparam opcode_t ALU_LSLI = 4'b1101;
   localparam opcode_t ALU_LSRI = 4'b1110;
   localparam opcode_t ALU_MOVI = 4'b1111;

   // Flow opcodes, top bit selects absolute over relative
   localparam int FLOW_ABS_BIT = 3;

   localparam opcode_t FLOW_BRA  = 4'b0000;
   localparam opcode_t FLOW_BAL  = 4'b0001;
   localparam opcode_t FLOW_BEQ  = 4'b0010;
   localparam opcode_t FLOW_BNE  = 4'b0011;
   localparam opcode_t FLOW_BLTS = 4'b0100;
   localparam opcode_t FLOW_BLES = 4'b0101;
   localparam opcode_t FLOW_BLTU = 4'b0110;
   localparam opcode_t FLOW_BLEU = 4'b0111;
   localparam opcode_t FLOW_JMP  = 4'b1000;
   localparam opcode_t FLOW_JAL  = 4'b1001;
   localparam opcode_t FLOW_JEQ  = 4'b1010;
   localparam opcode_t FLOW_JNE  = 4'b1011;
   localparam opcode_t FLOW_JLTS = 4'b1100;
   localparam opcode_t FLOW_JLES = 4'b1101;
   localparam opcode_t FLOW_JLTU = 4'b1110;
   localparam opcode_t FLOW_JLEU = 4'b1111;

endpackage

/* aap_regfile.sv */
`timescale 1ns/1ps

module aap_regfile (
   input  logic                   clk,
   input  logic                   rst,
   input  aap_core_pkg::reg_num_t rd_num_a,
   input  aap_core_pkg::reg_num_t rd_num_b,
   input  aap_core_pkg::reg_num_t rd_num_d,
   input  logic                   wr_en,
   input  aap_core_pkg::reg_num_t wr_num,
   input  aap_core_pkg::word_t    wr_data,
   output aap_core_pkg::word_t    rd_data_a,
   output aap_core_pkg::word_t    rd_data_b,
   output aap_core_pkg::word_t    rd_data_d
);

   import aap_core_pkg::*;

   // Register storage
   word_t regs [NUM_REGS];

   // **************************************************
   // Write port
   // **************************************************

   // Whole file starts at zero so programs see known values
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_num] <= wr_data;
      end
   end

   // **************************************************
   // Read ports
   // **************************************************

   // Combinational, no bypass
   // A write shows up on the cycle after the edge that lands it
   assign rd_data_a = regs[rd_num_a];
   assign rd_data_b = regs[rd_num_b];
   assign rd_data_d = regs[rd_num_d];

endmodule

/* aap_stim.txt */
// Columns: instr wb_en wb_num wb_data pc carry, all hex
// Expected values are state after the instruction completes
0000 1 0 0000 000001 0
1E7F 1 1 003F 000002 0
1E85 1 2 0005 000003 0
02CA 1 3 0044 000004 0
0511 1 4 FFC6 000005 1
0361 1 5 0005 000006 1
159B 1 6 0047 000007 0
17D7 1 7 FFFE 000008 1
1811 1 0 8002 000009 1
065E 1 1 0044 00000A 1
08A5 1 2 FFC7 00000B 1
0AD7 1 3 0039 00000C 1
1B1F 1 4 1C80 00000D 1
1151 1 5 0FFC 00000E 1
0DA0 1 6 C720 00000F 1
13E8 1 7 0FFC 000010 1
0E0A 1 0 2200 000011 1
1C73 1 1 18E4 000012 1
1491 1 2 FFC8 000013 0
18D2 1 3 3FF2 000014 0
44EF 0 0 0000 000017 0
47AF 0 0 0000 000018 0
4930 0 0 0000 000014 0
4CB0 0 0 0000 000015 0
4A6F 0 0 0000 000016 0
4FD3 0 0 0000 000017 0
41F0 0 0 0000 000007 0
4229 1 1 0008 00000C 0
40FF 0 0 0000 00010B 0
5140 0 0 0000 000FFC 0
5302 1 2 0FFD 001C80 0
5581 0 0 0000 001C81 0
5CC8 0 0 0000 003FF2 0
5BC6 0 0 0000 003FF3 0
2345 0 0 0000 003FF4 0
6ABC 0 0 0000 003FF5 0
9E4A 1 1 000A 003FF6 0
174A 1 5 0008 003FF7 0

/* filelist.f */
aap_core_pkg.sv
aap_isa_pkg.sv
aap_decode.sv
aap_regfile.sv
aap_execute.sv
aap_exec_core.sv
tb_aap_exec_core.sv

/* tb_aap_exec_core.sv */
`timescale 1ns/1ps

module tb_aap_exec_core;

   import aap_core_pkg::*;
   import aap_isa_pkg::*;

   // **************************************************
   // Run constants
   // **************************************************

   // One stimulus line per instruction, six hex fields per line
   localparam int NUM_TESTS    = 38;
   localparam int FIELDS       = 6;

   // Field offsets within a line
   localparam int F_INSTR      = 0;
   localparam int F_WB_EN      = 1;
   localparam int F_WB_NUM     = 2;
   localparam int F_WB_DATA    = 3;
   localparam int F_PC         = 4;
   localparam int F_CARRY      = 5;

   // Clock and drive timing in ns
   localparam int CLK_PERIOD   = 8;
   localparam int HALF_PERIOD  = 4;
   localparam int DRIVE_DELAY  = 1;
   localparam int RESET_CYCLES = 8;

   // Worst case is one idle cycle per word plus pipeline depth
   localparam int TIMEOUT_CYCLES = NUM_TESTS * 3 + 20;

   // Idle cycle choice
   localparam logic [15:0] LFSR_SEED = 16'd29;
   localparam logic [15:0] LFSR_TAPS = 16'hB400;

   // **************************************************
   // DUT signals
   // **************************************************

   logic     clk = 1'b0;
   logic     rst;
   logic     instr_valid;
   instr_t   instr;
   logic     done;
   logic     wb_en;
   reg_num_t wb_num;
   word_t    wb_data;
   pc_t      pc;
   logic     carry;

   // Flat copy of the stimulus file
   logic [PC_WIDTH-1:0] stim_mem [NUM_TESTS*FIELDS];

   logic [15:0] lfsr;

   aap_exec_core i_aap_exec_core (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .done        (done),
      .wb_en       (wb_en),
      .wb_num      (wb_num),
      .wb_data     (wb_data),
      .pc          (pc),
      .carry       (carry)
   );

   always #HALF_PERIOD clk = ~clk;

   // **************************************************
   // Helpers
   // **************************************************

   // Galois form, shifts right and folds the taps on a one out
   function automatic logic [15:0] lfsr_step(input logic [15:0] state);
      if (state[0]) begin
         return (state >> 1) ^ LFSR_TAPS;
      end else begin
         return state >> 1;
      end
   endfunction

   task automatic check_value(
      input string               name,
      input logic [PC_WIDTH-1:0] expected,
      input logic [PC_WIDTH-1:0] actual
   );
      if (expected !== actual) begin
         $display("[FAIL] %s expected %h actual %h", name, expected, actual);
         $display("TEST FAIL");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   // **************************************************
   // Reset and instruction driver
   // **************************************************

   initial begin
      rst         = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      lfsr        = LFSR_SEED;
      $readmemh("aap_stim.txt", stim_mem);

      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;

      for (int k = 0; k < NUM_TESTS; k++) begin
         @(posedge clk);
         #DRIVE_DELAY;
         instr_valid = 1'b1;
         instr       = stim_mem[k*FIELDS+F_INSTR][15:0];
         // One bit per word picks an idle gap after it
         lfsr = lfsr_step(lfsr);
         if (lfsr[0]) begin
            @(posedge clk);
            #DRIVE_DELAY;
            instr_valid = 1'b0;
         end
      end

      @(posedge clk);
      #DRIVE_DELAY;
      instr_valid = 1'b0;
   end

   // **************************************************
   // Result checker
   // **************************************************

   // Outputs are registered, so sample them on the falling edge
   initial begin
      int base;
      for (int k = 0; k < NUM_TESTS; k++) begin
         @(negedge clk);
         while (done !== 1'b1) begin
            @(negedge clk);
         end
         base = k * FIELDS;
         check_value($sformatf("test %0d wb_en", k + 1),
                     stim_mem[base+F_WB_EN], PC_WIDTH'(wb_en));
         // Write number and data mean nothing when no register is written
         if (stim_mem[base+F_WB_EN][0]) begin
            check_value($sformatf("test %0d wb_num", k + 1),
                        stim_mem[base+F_WB_NUM], PC_WIDTH'(wb_num));
            check_value($sformatf("test %0d wb_data", k + 1),
                        stim_mem[base+F_WB_DATA], PC_WIDTH'(wb_data));
         end
         check_value($sformatf("test %0d pc", k + 1),
                     stim_mem[base+F_PC], pc);
         check_value($sformatf("test %0d carry", k + 1),
                     stim_mem[base+F_CARRY], PC_WIDTH'(carry));
      end
      $display("All %0d instructions checked, pc is %0d bits wide", NUM_TESTS, PC_WIDTH);
      $display("TEST PASS");
      $finish;
   end

   // **************************************************
   // Watchdog
   // **************************************************

   initial begin
      #(TIMEOUT_CYCLES * CLK_PERIOD);
      $display("Timeout, not every instruction completed within %0d cycles",
               TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $fatal(1, "run stopped by watchdog");
   end

endmodule
